// File: src/noc_defines.svh
/* Router-wide width, port count and buffer depth macros */

`ifndef NOC_DEFINES_SVH
`define NOC_DEFINES_SVH

// Full flit width, dest byte plus payload byte
`define NOC_FLIT_W 16

// One mesh coordinate (row or column)
`define NOC_COORD_W 4

// Payload carried in the low byte of a flit
`define NOC_PAYLOAD_W 8

// South, west, east and local
`define NOC_NUM_PORTS 4

// Slots per input FIFO
// Also the credit count each output starts with
`define NOC_BUF_DEPTH 4

`endif

// File: src/noc_pkg.sv
/* Shared mesh types: coordinates, flits, links, port masks and port indices */

`include "noc_defines.svh"

package noc_pkg;

  // One mesh coordinate
  typedef logic [`NOC_COORD_W-1:0] coord_t;

  // Router address or flit destination, row above column
  typedef struct packed {
    coord_t y;
    coord_t x;
  } addr_t;

  typedef logic [`NOC_PAYLOAD_W-1:0] payload_t;

  // Single-flit packet
  typedef struct packed {
    addr_t    dest;
    payload_t payload;
  } flit_t;

  // One direction of one port
  typedef struct packed {
    logic  valid;
    flit_t flit;
  } link_t;

  // One bit per router port
  typedef logic [`NOC_NUM_PORTS-1:0] port_mask_t;

  // Bit positions in every port mask and port-indexed array
  localparam int PORT_S = 0;
  localparam int PORT_W = 1;
  localparam int PORT_E = 2;
  localparam int PORT_L = 3;

endpackage

// File: src/input_buffer.sv
/* Per-port input FIFO with link input register, head flit and empty flag */

`timescale 1ns/1ps
`include "noc_defines.svh"

module input_buffer #(
  parameter int DEPTH = `NOC_BUF_DEPTH
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  noc_pkg::link_t    link_i,
  input  logic              read_i,
  output noc_pkg::flit_t    head_o,
  output logic              empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Link input stage
  logic           in_valid_q;
  noc_pkg::flit_t in_flit_q;

  // Storage as raw flit words
  logic [`NOC_FLIT_W-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [CNT_W-1:0]       count_q;

  // Arriving flit lands here first
  // It enters the FIFO one edge later
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      in_valid_q <= 1'b0;
    end else begin
      in_valid_q <= link_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (link_i.valid) begin
      in_flit_q <= link_i.flit;
    end
  end

  // Write slot
  always_ff @(posedge clk) begin
    if (in_valid_q) begin
      mem_q[wr_ptr_q] <= in_flit_q;
    end
  end

  // Pointers wrap at DEPTH
  // Occupancy tracks push and pop in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (in_valid_q) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (read_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({in_valid_q, read_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Oldest flit, valid whenever not empty
  assign head_o  = noc_pkg::flit_t'(mem_q[rd_ptr_q]);
  assign empty_o = (count_q == '0);

endmodule

// File: src/credit_counter.sv
/* Free downstream slot counter for one router output */

`timescale 1ns/1ps
`include "noc_defines.svh"

module credit_counter #(
  parameter int DEPTH = `NOC_BUF_DEPTH
) (
  input  logic clk,
  input  logic rst_n_i,
  input  logic send_i,
  input  logic credit_i,
  output logic available_o
);

  localparam int CNT_W = $clog2(DEPTH + 1);

  // Free slots in the downstream buffer
  logic [CNT_W-1:0] count_q;

  // Starts full, one slot per downstream entry
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      count_q <= CNT_W'(DEPTH);
    end else begin
      case ({send_i, credit_i})
        // Flit leaves, slot consumed
        2'b10:   count_q <= count_q - 1'b1;
        // Slot returned downstream
        2'b01:   count_q <= count_q + 1'b1;
        // Both or neither, no net change
        default: count_q <= count_q;
      endcase
    end
  end

  // Output may be granted only with a free slot
  assign available_o = (count_q != '0);

endmodule

// File: src/route_decoder.sv
/* YX route computation for a top-row router */

`timescale 1ns/1ps

module route_decoder (
  input  noc_pkg::flit_t     head_i,
  input  noc_pkg::addr_t     yx_addr_router_i,
  output noc_pkg::port_mask_t request_o
);

  // Destination pieces of the head flit
  noc_pkg::coord_t dest_y;
  noc_pkg::coord_t dest_x;

  assign dest_y = head_i.dest.y;
  assign dest_x = head_i.dest.x;

  // Row first, then column
  always_comb begin
    request_o = '0;
    if (dest_y != yx_addr_router_i.y) begin
      // Top row, so any other row lies south
      request_o[noc_pkg::PORT_S] = 1'b1;
    end else if (dest_x > yx_addr_router_i.x) begin
      // Columns grow toward east
      request_o[noc_pkg::PORT_E] = 1'b1;
    end else if (dest_x < yx_addr_router_i.x) begin
      request_o[noc_pkg::PORT_W] = 1'b1;
    end else begin
      // Arrived
      request_o[noc_pkg::PORT_L] = 1'b1;
    end
  end

endmodule

// File: src/switch_allocator.sv
/* Round-robin switch allocator per output, gated by buffer state and credit */

`timescale 1ns/1ps
`include "noc_defines.svh"

module switch_allocator #(
  parameter int SEL_W = $clog2(`NOC_NUM_PORTS)
) (
  input  logic                clk,
  input  logic                rst_n_i,
  input  noc_pkg::port_mask_t request_i [`NOC_NUM_PORTS],
  input  noc_pkg::port_mask_t empty_i,
  input  noc_pkg::port_mask_t available_i,
  output noc_pkg::port_mask_t read_o,
  output noc_pkg::port_mask_t send_o,
  output logic [SEL_W-1:0]    select_o [`NOC_NUM_PORTS]
);

  localparam int NUM = `NOC_NUM_PORTS;

  // Per output, which inputs hold a live request for it
  noc_pkg::port_mask_t cand [NUM];

  // Per output, last granted input
  logic [SEL_W-1:0] ptr_q [NUM];

  // Per output search result
  logic [SEL_W-1:0] winner [NUM];
  noc_pkg::port_mask_t hit;

  // Transpose requests to output view
  // Empty buffers show stale heads, so mask them
  always_comb begin
    for (int o = 0; o < NUM; o++) begin
      for (int i = 0; i < NUM; i++) begin
        cand[o][i] = request_i[i][o] & ~empty_i[i];
      end
    end
  end

  // Search from farthest to nearest after the pointer
  // Last match wins, i.e. the first input after the pointer
  always_comb begin
    for (int o = 0; o < NUM; o++) begin
      hit[o]    = 1'b0;
      winner[o] = ptr_q[o];
      for (int k = NUM; k >= 1; k--) begin
        if (cand[o][(int'(ptr_q[o]) + k) % NUM]) begin
          hit[o]    = 1'b1;
          winner[o] = SEL_W'((int'(ptr_q[o]) + k) % NUM);
        end
      end
      // No grant without a downstream slot
      send_o[o]   = hit[o] & available_i[o];
      select_o[o] = winner[o];
    end
  end

  // Pop the winning input of every granted output
  // One request per input, so at most one grant each
  always_comb begin
    read_o = '0;
    for (int o = 0; o < NUM; o++) begin
      if (send_o[o]) begin
        read_o[winner[o]] = 1'b1;
      end
    end
  end

  // Pointer moves past the winner only on a grant
  // Reset to last input, so input 0 leads after reset
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int o = 0; o < NUM; o++) begin
        ptr_q[o] <= SEL_W'(NUM - 1);
      end
    end else begin
      for (int o = 0; o < NUM; o++) begin
        if (send_o[o]) begin
          ptr_q[o] <= winner[o];
        end
      end
    end
  end

endmodule

// File: src/crossbar_switch.sv
/* Crossbar output muxes with registered output links */

`timescale 1ns/1ps
`include "noc_defines.svh"

module crossbar_switch #(
  parameter int SEL_W = $clog2(`NOC_NUM_PORTS)
) (
  input  logic                clk,
  input  logic                rst_n_i,
  input  noc_pkg::flit_t      head_i [`NOC_NUM_PORTS],
  input  noc_pkg::port_mask_t send_i,
  input  logic [SEL_W-1:0]    select_i [`NOC_NUM_PORTS],
  output noc_pkg::link_t      link_o [`NOC_NUM_PORTS]
);

  // Output valid per port
  noc_pkg::port_mask_t valid_q;
  // Output payload registers
  noc_pkg::flit_t      flit_q [`NOC_NUM_PORTS];

  // Valid lasts one cycle per grant
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= send_i;
    end
  end

  // Capture selected head only on a grant
  always_ff @(posedge clk) begin
    for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
      if (send_i[o]) begin
        flit_q[o] <= head_i[select_i[o]];
      end
    end
  end

  for (genvar o = 0; o < `NOC_NUM_PORTS; o++) begin : gen_out
    assign link_o[o].valid = valid_q[o];
    assign link_o[o].flit  = flit_q[o];
  end

endmodule

// File: src/n_edge_router.sv
/* North-edge mesh router top: input FIFOs, YX decoders, allocator,
   credit counters and crossbar */

`timescale 1ns/1ps
`include "noc_defines.svh"

module n_edge_router (
  input  logic                clk,
  input  logic                rst_n_i,
  input  noc_pkg::addr_t      yx_addr_router_i,
  input  noc_pkg::link_t      link_i [`NOC_NUM_PORTS],
  output noc_pkg::port_mask_t credit_o,
  output noc_pkg::link_t      link_o [`NOC_NUM_PORTS],
  input  noc_pkg::port_mask_t credit_i
);

  localparam int SEL_W = $clog2(`NOC_NUM_PORTS);

  // Buffer heads and state
  noc_pkg::flit_t      head [`NOC_NUM_PORTS];
  noc_pkg::port_mask_t empty;

  // One-hot output request per input
  noc_pkg::port_mask_t request [`NOC_NUM_PORTS];

  // Downstream slot available per output
  noc_pkg::port_mask_t available;

  // Allocator results
  noc_pkg::port_mask_t read;
  noc_pkg::port_mask_t send;
  logic [SEL_W-1:0]    select [`NOC_NUM_PORTS];

  // Per-port slices, indexed by the port constants
  for (genvar p = 0; p < `NOC_NUM_PORTS; p++) begin : gen_port

    input_buffer #(
      .DEPTH (`NOC_BUF_DEPTH)
    ) i_input_buffer (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .link_i  (link_i[p]),
      .read_i  (read[p]),
      .head_o  (head[p]),
      .empty_o (empty[p])
    );

    route_decoder i_route_decoder (
      .head_i           (head[p]),
      .yx_addr_router_i (yx_addr_router_i),
      .request_o        (request[p])
    );

    // Tracks the downstream buffer behind output p
    credit_counter #(
      .DEPTH (`NOC_BUF_DEPTH)
    ) i_credit_counter (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .send_i      (send[p]),
      .credit_i    (credit_i[p]),
      .available_o (available[p])
    );

  end

  switch_allocator #(
    .SEL_W (SEL_W)
  ) i_switch_allocator (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .request_i   (request),
    .empty_i     (empty),
    .available_i (available),
    .read_o      (read),
    .send_o      (send),
    .select_o    (select)
  );

  crossbar_switch #(
    .SEL_W (SEL_W)
  ) i_crossbar_switch (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .head_i   (head),
    .send_i   (send),
    .select_i (select),
    .link_o   (link_o)
  );

  // Every buffer pop frees one upstream slot
  assign credit_o = read;

endmodule

// File: testbench/n_edge_router_properties.sv
/* Bound router checks: downstream credit, input FIFO room and occupancy,
   reset */

`timescale 1ns/1ps
`include "noc_defines.svh"

module n_edge_router_properties (
  input logic                clk,
  input logic                rst_n_i,
  input noc_pkg::link_t      link_in_i [`NOC_NUM_PORTS],
  input noc_pkg::link_t      link_out_i [`NOC_NUM_PORTS],
  input noc_pkg::port_mask_t credit_out_i,
  input noc_pkg::port_mask_t credit_in_i
);

  // Free slots per input FIFO, link register included
  int room [`NOC_NUM_PORTS];
  // Free slots behind each output, seen from the output links
  int down_free [`NOC_NUM_PORTS];
  // Flits held per input FIFO, one edge behind the link
  int occupancy [`NOC_NUM_PORTS];
  noc_pkg::port_mask_t write_q;

  always_ff @(posedge clk) begin
    for (int p = 0; p < `NOC_NUM_PORTS; p++) begin
      if (!rst_n_i) begin
        room[p]      <= `NOC_BUF_DEPTH;
        down_free[p] <= `NOC_BUF_DEPTH;
        occupancy[p] <= 0;
        write_q[p]   <= 1'b0;
      end else begin
        room[p]      <= room[p] - int'(link_in_i[p].valid) + int'(credit_out_i[p]);
        down_free[p] <= down_free[p] - int'(link_out_i[p].valid) + int'(credit_in_i[p]);
        occupancy[p] <= occupancy[p] + int'(write_q[p]) - int'(credit_out_i[p]);
        write_q[p]   <= link_in_i[p].valid;
      end
    end
  end

  for (genvar p = 0; p < `NOC_NUM_PORTS; p++) begin : gen_chk
    // Delivered flit needs a downstream slot
    a_send_credit: assert property (@(posedge clk) disable iff (!rst_n_i)
      link_out_i[p].valid |-> down_free[p] > 0)
      else $error("Output %0d delivered without downstream credit", p);

    // Upstream must not write into a full FIFO
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
      link_in_i[p].valid |-> room[p] != 0)
      else $error("Input %0d written while its buffer is full", p);

    // Pop only from a FIFO holding a flit
    a_credit_nonempty: assert property (@(posedge clk) disable iff (!rst_n_i)
      credit_out_i[p] |-> occupancy[p] > 0)
      else $error("Credit returned from empty input %0d", p);

    // Output registers cleared by reset
    a_reset_clear: assert property (@(posedge clk)
      !rst_n_i |=> !link_out_i[p].valid)
      else $error("Output %0d valid right after reset", p);
  end

endmodule

bind n_edge_router n_edge_router_properties i_properties (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .link_in_i    (link_i),
  .link_out_i   (link_o),
  .credit_out_i (credit_o),
  .credit_in_i  (credit_i)
);

// File: testbench/tb_n_edge_router.sv
/* Router testbench: route table, upstream and downstream credit models,
   per input/output scoreboard, credit hold and local contention phases */

`timescale 1ns/1ps
`include "noc_defines.svh"

module tb_n_edge_router;

  localparam int NP      = `NOC_NUM_PORTS;
  localparam int TIMEOUT = 300;
  localparam int NROWS   = 12;

  // One table entry, payload top bits tag the source port
  typedef struct packed {
    logic [1:0]        src;
    noc_pkg::addr_t    dest;
    noc_pkg::payload_t payload;
    logic [1:0]        exp;
  } row_t;

  // Ports 0 south, 1 west, 2 east, 3 local; router at y=0 x=2
  localparam row_t ROWS [NROWS] = '{
    '{2'd3, 8'h12, 8'hc1, 2'd0},  // Other row goes south
    '{2'd1, 8'h31, 8'h41, 2'd0},
    '{2'd3, 8'h00, 8'hc2, 2'd1},  // Lower column goes west
    '{2'd2, 8'h01, 8'h81, 2'd1},
    '{2'd3, 8'h05, 8'hc3, 2'd2},  // Higher column goes east
    '{2'd0, 8'h03, 8'h01, 2'd2},
    '{2'd1, 8'h0f, 8'h42, 2'd2},
    '{2'd0, 8'h02, 8'h02, 2'd3},  // Own address goes local
    '{2'd2, 8'h02, 8'h82, 2'd3},
    '{2'd3, 8'h12, 8'hc4, 2'd0},  // Back to back on one pair
    '{2'd3, 8'h12, 8'hc5, 2'd0},
    '{2'd3, 8'h12, 8'hc6, 2'd0}
  };

  logic                clk;
  logic                rst_n_i;
  noc_pkg::addr_t      router_addr;
  noc_pkg::link_t      link_i [NP];
  noc_pkg::link_t      link_o [NP];
  noc_pkg::port_mask_t credit_i;
  noc_pkg::port_mask_t credit_o;

  // Expected flits per source and output
  noc_pkg::flit_t      expect_q [NP][NP][$];
  int                  up_credit [NP];
  int                  owed [NP];
  int                  grant_credit [NP];
  int                  sent_cnt [NP];
  int                  credit_cnt [NP];
  int                  out_cnt [NP];
  int                  last_out_cycle [NP];
  int                  sent_total;
  int                  cycle = 0;
  bit                  hold_credit;
  bit                  check_fair;
  noc_pkg::port_mask_t served;
  logic [31:0]         rnd_state = 32'h8013_f027;

  n_edge_router i_dut (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .yx_addr_router_i (router_addr),
    .link_i           (link_i),
    .credit_o         (credit_o),
    .link_o           (link_o),
    .credit_i         (credit_i)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  // Inputs change just after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  // True once every flit has left and every slot is returned
  function automatic bit all_idle();
    for (int s = 0; s < NP; s++) begin
      if (owed[s] != 0) return 1'b0;
      for (int o = 0; o < NP; o++) begin
        if (expect_q[s][o].size() != 0) return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // Waits for upstream credit, then drives one flit for one cycle
  task automatic send_flit(input int p, input noc_pkg::flit_t f, input int o);
    int waited;
    waited = 0;
    while (up_credit[p] == 0) begin
      tick();
      waited++;
      assert (waited <= TIMEOUT)
        else stop_run($sformatf("Timeout waiting for upstream credit on port %0d", p));
    end
    link_i[p].valid = 1'b1;
    link_i[p].flit  = f;
    expect_q[p][o].push_back(f);
    up_credit[p]--;
    sent_cnt[p]++;
    sent_total++;
    tick();
    link_i[p].valid = 1'b0;
  endtask

  task automatic wait_count(input int o, input int n);
    int waited;
    waited = 0;
    while (out_cnt[o] < n) begin
      tick();
      waited++;
      assert (waited <= TIMEOUT)
        else stop_run($sformatf("Timeout waiting for %0d flits on output %0d", n, o));
    end
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (!all_idle()) begin
      tick();
      waited++;
      assert (waited <= TIMEOUT)
        else stop_run("Timeout waiting for flits to leave and credits to return");
    end
  endtask

  // Scoreboard match, order per pair, local fairness
  task automatic check_delivery(input int o, input noc_pkg::flit_t f);
    int             src;
    noc_pkg::flit_t want;
    src = int'(f.payload[7:6]);
    assert (expect_q[src][o].size() > 0)
      else stop_run($sformatf("Error at time %0t: unexpected flit %h on output %0d",
                              $time, f, o));
    want = expect_q[src][o].pop_front();
    assert (f == want)
      else stop_run($sformatf("Error at time %0t: output %0d got %h, expected %h",
                              $time, o, f, want));
    if (check_fair && o == noc_pkg::PORT_L) begin
      // Repeat source allowed only once every waiting source had a turn
      if (served[src]) begin
        for (int s = 0; s < NP; s++) begin
          assert (s == src || served[s] || expect_q[s][o].size() == 0)
            else stop_run($sformatf("Error at time %0t: source %0d served twice while %0d waits",
                                    $time, src, s));
        end
        served = '0;
      end
      served[src] = 1'b1;
    end
    out_cnt[o]++;
    owed[o]++;
    last_out_cycle[o] = cycle;
  endtask

  // Outputs sampled mid-cycle where they are stable
  always @(negedge clk) begin
    if (rst_n_i) begin
      for (int p = 0; p < NP; p++) begin
        assert (sent_total > 0 || (!credit_o[p] && !link_o[p].valid))
          else stop_run($sformatf("Error at time %0t: activity on port %0d before any flit",
                                  $time, p));
        if (credit_o[p]) begin
          up_credit[p]++;
          credit_cnt[p]++;
        end
        if (link_o[p].valid) begin
          check_delivery(p, link_o[p].flit);
        end
      end
    end
  end

  // Downstream slots come back after random delays, or on command while held
  always @(posedge clk) begin
    #1;
    for (int o = 0; o < NP; o++) begin
      rnd_state   = xorshift(rnd_state);
      credit_i[o] = 1'b0;
      if (hold_credit) begin
        if (grant_credit[o] > 0 && owed[o] > 0) begin
          credit_i[o] = 1'b1;
          grant_credit[o]--;
          owed[o]--;
        end
      end else if (owed[o] > 0 && rnd_state[1:0] == 2'b00) begin
        credit_i[o] = 1'b1;
        owed[o]--;
      end
    end
  end

  initial begin
    noc_pkg::flit_t flit;
    int             start;
    int             base;
    rst_n_i     = 1'b0;
    router_addr = 8'h02;
    credit_i    = '0;
    hold_credit = 1'b0;
    check_fair  = 1'b0;
    served      = '0;
    sent_total  = 0;
    for (int p = 0; p < NP; p++) begin
      link_i[p]       = '0;
      up_credit[p]    = `NOC_BUF_DEPTH;
      owed[p]         = 0;
      grant_credit[p] = 0;
      sent_cnt[p]     = 0;
      credit_cnt[p]   = 0;
      out_cnt[p]      = 0;
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n_i = 1'b1;

    // Quiet router, then one isolated flit west to east
    repeat (6) tick();
    start = cycle;
    send_flit(noc_pkg::PORT_W, 16'h05_40, noc_pkg::PORT_E);
    wait_count(noc_pkg::PORT_E, 1);
    assert (last_out_cycle[noc_pkg::PORT_E] - (start + 1) == 2)
      else stop_run($sformatf("Error at time %0t: isolated flit latency %0d cycles",
                              $time, last_out_cycle[noc_pkg::PORT_E] - (start + 1)));
    wait_drained();

    // Route table with random credit return
    for (int r = 0; r < NROWS; r++) begin
      flit = '{dest: ROWS[r].dest, payload: ROWS[r].payload};
      send_flit(int'(ROWS[r].src), flit, int'(ROWS[r].exp));
    end
    wait_drained();

    // All inputs to local with credit held
    base        = out_cnt[noc_pkg::PORT_L];
    hold_credit = 1'b1;
    for (int i = 0; i < 4 * NP; i++) begin
      flit = '{dest: 8'h02, payload: {2'(i % NP), 6'(i + 16)}};
      send_flit(i % NP, flit, noc_pkg::PORT_L);
    end
    wait_count(noc_pkg::PORT_L, base + `NOC_BUF_DEPTH);
    repeat (20) tick();
    assert (out_cnt[noc_pkg::PORT_L] == base + `NOC_BUF_DEPTH)
      else stop_run($sformatf("Error at time %0t: %0d local flits without credit",
                              $time, out_cnt[noc_pkg::PORT_L] - base));

    // Three returned slots release three flits
    check_fair                    = 1'b1;
    grant_credit[noc_pkg::PORT_L] = 3;
    wait_count(noc_pkg::PORT_L, base + `NOC_BUF_DEPTH + 3);
    repeat (20) tick();
    assert (out_cnt[noc_pkg::PORT_L] == base + `NOC_BUF_DEPTH + 3)
      else stop_run($sformatf("Error at time %0t: %0d local flits after 3 credits",
                              $time, out_cnt[noc_pkg::PORT_L] - base));
    hold_credit = 1'b0;
    wait_drained();
    check_fair = 1'b0;

    // Every flit in came back as one upstream credit
    for (int p = 0; p < NP; p++) begin
      assert (credit_cnt[p] == sent_cnt[p])
        else stop_run($sformatf("Error at time %0t: port %0d credits %0d, flits %0d",
                                $time, p, credit_cnt[p], sent_cnt[p]));
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: Bender.yml
package:
  name: n_edge_router

sources:
  # Package and RTL, headers from src
  - include_dirs:
      - src
    files:
      - src/noc_pkg.sv
      - src/input_buffer.sv
      - src/credit_counter.sv
      - src/route_decoder.sv
      - src/switch_allocator.sv
      - src/crossbar_switch.sv
      - src/n_edge_router.sv
  # Bound checks and testbench
  - target: test
    include_dirs:
      - src
    files:
      - testbench/n_edge_router_properties.sv
      - testbench/tb_n_edge_router.sv

// File: tb.f
+incdir+src
src/noc_pkg.sv
src/input_buffer.sv
src/credit_counter.sv
src/route_decoder.sv
src/switch_allocator.sv
src/crossbar_switch.sv
src/n_edge_router.sv
testbench/n_edge_router_properties.sv
testbench/tb_n_edge_router.sv
